// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_pong
FILELIST   := sim.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
RUN_ARGS   := +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hdl/ball_ctrl.sv ====
module ball_ctrl
    import pong_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  paddles_t paddles,
    input  logic     ball_tick,   // move strobe
    input  logic     serve_done,  // serve delay elapsed
    output ball_t    ball,
    output logic     serving      // ball parked, waiting to launch
);

    y_t    paddle_y;   // paddle on the side the ball heads to
    zone_e zone;
    logic  upper;
    logic  at_face;    // ball reaches the paddle face this tick
    logic  hit;
    logic  scored;     // ball already behind a face
    vel_t  hit_xvel;
    vel_t  hit_yvel;
    ball_t moved;      // ball after one tick

    assign paddle_y = (ball.xdir == XDIR_LEFT) ? paddles.left_y : paddles.right_y;

    hit_zone i_hit_zone (
        .ball     (ball),
        .paddle_y (paddle_y),
        .zone     (zone),
        .upper    (upper)
    );

    assign at_face = (ball.xdir == XDIR_LEFT)
                   ? (int'(ball.x) - int'(ball.xvel) <= LEFT_FACE_X)
                   : (int'(ball.x) + BALL_WIDTH + int'(ball.xvel) >= RIGHT_FACE_X);
    assign hit     = at_face && (zone != ZONE_MISS);
    assign scored  = (int'(ball.x) < LEFT_FACE_X) || (int'(ball.x) > RIGHT_FACE_X);

    // rebound speeds by band
    always_comb begin
        hit_xvel = vel_t'(CENTER_XVEL);
        hit_yvel = vel_t'(CENTER_YVEL);
        case (zone)
            ZONE_EDGE: begin
                hit_xvel = vel_t'(EDGE_XVEL);
                hit_yvel = vel_t'(EDGE_YVEL);
            end
            ZONE_MID: begin
                hit_xvel = vel_t'(MID_XVEL);
                hit_yvel = vel_t'(MID_YVEL);
            end
            default: ;
        endcase
    end

    always_comb begin
        moved = ball;
        if (hit) begin
            moved.xvel = hit_xvel;
            moved.yvel = hit_yvel;
            if (ball.xdir == XDIR_LEFT) begin
                moved.xdir = XDIR_RIGHT;                           // bounce off left paddle
                moved.x    = x_t'(int'(ball.x) + int'(hit_xvel));
            end else begin
                moved.xdir = XDIR_LEFT;                            // bounce off right paddle
                moved.x    = x_t'(int'(ball.x) - int'(hit_xvel));
            end
            if (zone == ZONE_CENTER) begin
                moved.ydir = YDIR_PARALLEL;                        // flattened
            end else if (ball.ydir == YDIR_PARALLEL) begin
                moved.ydir = upper ? YDIR_UP : YDIR_DOWN;          // deflect away from centre
            end
        end else begin
            if (ball.xdir == XDIR_LEFT) begin
                moved.x = x_t'(int'(ball.x) - int'(ball.xvel));
            end else begin
                moved.x = x_t'(int'(ball.x) + int'(ball.xvel));
            end
            case (ball.ydir)
                YDIR_DOWN: begin
                    if (int'(ball.y) + BALL_HEIGHT + int'(ball.yvel) >= SCREEN_HEIGHT) begin
                        moved.y    = y_t'(int'(ball.y) - int'(ball.yvel));  // bottom wall
                        moved.ydir = YDIR_UP;
                    end else begin
                        moved.y = y_t'(int'(ball.y) + int'(ball.yvel));
                    end
                end
                YDIR_UP: begin
                    if (ball.y < y_t'(ball.yvel)) begin
                        moved.y    = y_t'(int'(ball.y) + int'(ball.yvel));  // top wall
                        moved.ydir = YDIR_DOWN;
                    end else begin
                        moved.y = y_t'(int'(ball.y) - int'(ball.yvel));
                    end
                end
                default: ;                                         // parallel keeps y
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ball.x    <= x_t'(BALL_INIT_X);
            ball.y    <= y_t'(BALL_INIT_Y);
            ball.xdir <= XDIR_LEFT;
            ball.ydir <= YDIR_PARALLEL;
            ball.xvel <= '0;
            ball.yvel <= '0;
            serving   <= 1'b1;                 // first serve after the delay
        end else if (serving) begin
            ball.x    <= x_t'(BALL_INIT_X);    // parked, xdir left as it was
            ball.y    <= y_t'(BALL_INIT_Y);
            ball.ydir <= YDIR_PARALLEL;
            ball.xvel <= serve_done ? vel_t'(SERVE_VEL) : '0;
            ball.yvel <= '0;
            if (serve_done) begin
                serving <= 1'b0;               // launch
            end
        end else if (ball_tick) begin
            ball <= moved;
            if (scored) begin
                serving <= 1'b1;               // point over, reset on next edge
            end
        end
    end

endmodule

// ==== hdl/button_sync.sv ====
module button_sync
    import pong_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  buttons_t buttons,  // raw board inputs
    output buttons_t press     // one-cycle pulse per press
);

    buttons_t sync1;  // first metastability stage
    buttons_t sync2;  // stable copy
    buttons_t prev;   // sync2 one cycle back

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sync1 <= '0;
            sync2 <= '0;
            prev  <= '0;
        end else begin
            sync1 <= buttons;
            sync2 <= sync1;
            prev  <= sync2;  // edge detect history
        end
    end

    // rising level only, a held button stays quiet after the first cycle
    assign press = sync2 & ~prev;

endmodule

// ==== hdl/hit_zone.sv ====
module hit_zone
    import pong_pkg::*;
(
    input  ball_t ball,
    input  y_t    paddle_y,  // top of the paddle being approached
    output zone_e zone,
    output logic  upper      // ball in the upper half of the band hit
);

    int by;          // ball top
    int py;          // paddle top
    logic overlap;

    assign by = int'(ball.y);
    assign py = int'(paddle_y);

    // vertical spans touch, x is judged by the caller
    assign overlap = (by + BALL_HEIGHT >= py) && (by <= py + PADDLE_HEIGHT);

    always_comb begin
        zone  = ZONE_MISS;
        upper = 1'b0;
        if (!overlap) begin
            zone = ZONE_MISS;
        end else if (by < py + EDGE_TOP || by > py + EDGE_BOT) begin
            zone  = ZONE_EDGE;                // outermost strips
            upper = (by < py + EDGE_TOP);
        end else if (by < py + MID_TOP || by > py + MID_BOT) begin
            zone  = ZONE_MID;
            upper = (by < py + MID_TOP);
        end else begin
            zone  = ZONE_CENTER;
            upper = (by + BALL_HEIGHT / 2 < py + PADDLE_MID);  // ball centre above paddle centre
        end
    end

endmodule

// ==== hdl/paddle_ctrl.sv ====
module paddle_ctrl
    import pong_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic up,    // press pulse, move toward y = 0
    input  logic down,  // press pulse, move toward the bottom
    output y_t   y      // paddle top edge
);

    logic move_up;
    logic move_down;

    // both at once cancel out
    assign move_up   = up && !down;
    assign move_down = down && !up;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            y <= y_t'(PADDLE_INIT_Y);  // centred
        end else if (move_up) begin
            if (int'(y) < PADDLE_STEP) begin
                y <= '0;                            // pinned at the top
            end else begin
                y <= y_t'(int'(y) - PADDLE_STEP);
            end
        end else if (move_down) begin
            if (int'(y) + PADDLE_HEIGHT + PADDLE_STEP >= SCREEN_HEIGHT) begin
                y <= y_t'(PADDLE_Y_MAX);            // pinned at the bottom
            end else begin
                y <= y_t'(int'(y) + PADDLE_STEP);
            end
        end
    end

endmodule

// ==== hdl/pong_game.sv ====
module pong_game
    import pong_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  buttons_t buttons,  // raw player buttons
    output paddles_t paddles,
    output ball_t    ball,
    output logic     serving
);

    buttons_t press;       // press pulses
    logic     ball_tick;   // ball step strobe
    logic     serve_done;  // end of serve delay
    y_t       left_y;
    y_t       right_y;

    button_sync i_button_sync (
        .clk     (clk),
        .rst     (rst),
        .buttons (buttons),
        .press   (press)
    );

    tick_timer #(
        .PERIOD (BALL_TICK_CYCLES)
    ) i_ball_timer (
        .clk  (clk),
        .rst  (rst),
        .en   (1'b1),          // free running
        .tick (ball_tick)
    );

    tick_timer #(
        .PERIOD (SERVE_DELAY_CYCLES)
    ) i_serve_timer (
        .clk  (clk),
        .rst  (rst),
        .en   (serving),       // runs only while parked
        .tick (serve_done)
    );

    paddle_ctrl i_left_paddle (
        .clk  (clk),
        .rst  (rst),
        .up   (press.left_up),
        .down (press.left_down),
        .y    (left_y)
    );

    paddle_ctrl i_right_paddle (
        .clk  (clk),
        .rst  (rst),
        .up   (press.right_up),
        .down (press.right_down),
        .y    (right_y)
    );

    assign paddles = '{left_y: left_y, right_y: right_y};

    ball_ctrl i_ball_ctrl (
        .clk        (clk),
        .rst        (rst),
        .paddles    (paddles),
        .ball_tick  (ball_tick),
        .serve_done (serve_done),
        .ball       (ball),
        .serving    (serving)
    );

endmodule

// ==== hdl/pong_pkg.sv ====
package pong_pkg;

    // playfield geometry in pixels
    localparam int SCREEN_WIDTH  = 400;
    localparam int SCREEN_HEIGHT = 600;
    localparam int X_BITS        = $clog2(SCREEN_WIDTH);   // 9 bits for x
    localparam int Y_BITS        = $clog2(SCREEN_HEIGHT);  // 10 bits for y

    // paddles
    localparam int PADDLE_LEFT_X  = 10;                             // outer edge, left
    localparam int PADDLE_RIGHT_X = SCREEN_WIDTH - PADDLE_LEFT_X;   // outer edge, right
    localparam int PADDLE_WIDTH   = 7;
    localparam int PADDLE_HEIGHT  = 150;
    localparam int PADDLE_MID     = PADDLE_HEIGHT / 2;              // paddle centre line
    localparam int PADDLE_STEP    = 8;                              // pixels per press
    localparam int PADDLE_INIT_Y  = 225;
    localparam int PADDLE_Y_MAX   = SCREEN_HEIGHT - PADDLE_HEIGHT;  // lowest legal top
    localparam int LEFT_FACE_X    = PADDLE_LEFT_X + PADDLE_WIDTH;   // ball-side face
    localparam int RIGHT_FACE_X   = PADDLE_RIGHT_X - PADDLE_WIDTH;

    // ball
    localparam int BALL_WIDTH  = 4;
    localparam int BALL_HEIGHT = BALL_WIDTH * 2;
    localparam int BALL_INIT_X = 197;  // roughly screen centre
    localparam int BALL_INIT_Y = 295;
    localparam int SERVE_VEL   = 3;    // flat serve toward the last loser

    // paddle bands, offsets from the paddle top
    localparam int EDGE_TOP = BALL_HEIGHT;                  // above this is the top edge
    localparam int EDGE_BOT = PADDLE_HEIGHT - BALL_HEIGHT;  // below this is the bottom edge
    localparam int MID_TOP  = PADDLE_MID - BALL_HEIGHT;     // centre band spans MID_TOP..MID_BOT
    localparam int MID_BOT  = PADDLE_MID + BALL_HEIGHT;

    // rebound velocities per band
    localparam int EDGE_XVEL   = 1;  // steep and slow across
    localparam int EDGE_YVEL   = 3;
    localparam int MID_XVEL    = 2;  // diagonal
    localparam int MID_YVEL    = 2;
    localparam int CENTER_XVEL = 3;  // flat and fast
    localparam int CENTER_YVEL = 0;

    // timers, scaled down for simulation
    localparam int BALL_TICK_CYCLES   = 8;
    localparam int SERVE_DELAY_CYCLES = 64;

    typedef logic [X_BITS-1:0] x_t;
    typedef logic [Y_BITS-1:0] y_t;
    typedef logic [1:0]        vel_t;  // pixels per tick

    typedef enum logic {
        XDIR_LEFT  = 1'b0,
        XDIR_RIGHT = 1'b1
    } xdir_e;

    typedef enum logic [1:0] {
        YDIR_PARALLEL = 2'b00,
        YDIR_DOWN     = 2'b01,
        YDIR_UP       = 2'b10
    } ydir_e;

    typedef enum logic [1:0] {
        ZONE_MISS   = 2'd0,
        ZONE_EDGE   = 2'd1,
        ZONE_MID    = 2'd2,
        ZONE_CENTER = 2'd3
    } zone_e;

    typedef struct packed {
        logic left_up;
        logic left_down;
        logic right_up;
        logic right_down;
    } buttons_t;

    typedef struct packed {
        x_t    x;     // top left corner
        y_t    y;
        xdir_e xdir;
        ydir_e ydir;
        vel_t  xvel;
        vel_t  yvel;
    } ball_t;

    typedef struct packed {
        y_t left_y;   // paddle top edges
        y_t right_y;
    } paddles_t;

endpackage

// ==== hdl/tick_timer.sv ====
module tick_timer #(
    parameter int PERIOD = 8  // enabled cycles per pulse
) (
    input  logic clk,
    input  logic rst,
    input  logic en,    // count enable, clears when low
    output logic tick   // high on the last count of a period
);

    logic [$clog2(PERIOD)-1:0] cnt;

    assign tick = en && (cnt == $bits(cnt)'(PERIOD - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (!en) begin
            cnt <= '0;      // restart the period on next enable
        end else if (tick) begin
            cnt <= '0;      // wrap
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

// ==== sim.f ====
hdl/pong_pkg.sv
hdl/button_sync.sv
hdl/tick_timer.sv
hdl/paddle_ctrl.sv
hdl/hit_zone.sv
hdl/ball_ctrl.sv
hdl/pong_game.sv
sim/pong_props.sv
sim/tb_clock.sv
sim/tb_pong.sv

// ==== sim/pong_props.sv ====
module pong_props
    import pong_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input ball_t ball,
    input logic  serving
);

    int unsigned violations = 0;  // read by tb_pong before the verdict

    // one edge after serving the ball is parked, it only gains xvel at launch
    a_parked: assert property (@(posedge clk) disable iff (rst)
        serving |=> (int'(ball.x) == BALL_INIT_X) && (int'(ball.y) == BALL_INIT_Y)
                    && (ball.yvel == '0) && (ball.ydir == YDIR_PARALLEL)
                    && ((ball.xvel == '0) || !serving))
    else begin
        violations++;
        $error("ball not parked at the serve position");
    end

    a_y_range: assert property (@(posedge clk) disable iff (rst)
        int'(ball.y) <= SCREEN_HEIGHT - BALL_HEIGHT)  // bottom of ball stays on screen
    else begin
        violations++;
        $error("ball y out of the playfield");
    end

    a_moving: assert property (@(posedge clk) disable iff (rst)
        !serving |-> (ball.xvel != '0))
    else begin
        violations++;
        $error("ball stalled in x while in play");
    end

endmodule

bind ball_ctrl pong_props i_pong_props (
    .clk     (clk),
    .rst     (rst),
    .ball    (ball),
    .serving (serving)
);

// ==== sim/tb_clock.sv ====
module tb_clock (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD = 20;  // 40 per cycle

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);  // two cycles in reset
        rst <= 1'b0;
    end

endmodule

// ==== sim/tb_pong.sv ====
module tb_pong
    import pong_pkg::*;
;

    localparam int RUN_CYCLES     = 4000;            // three rallies and two serves
    localparam int TIMEOUT_CYCLES = RUN_CYCLES * 5;  // wide margin
    localparam buttons_t LEFT_UP    = '{1'b1, 1'b0, 1'b0, 1'b0};
    localparam buttons_t LEFT_DOWN  = '{1'b0, 1'b1, 1'b0, 1'b0};
    localparam buttons_t LEFT_BOTH  = '{1'b1, 1'b1, 1'b0, 1'b0};
    localparam buttons_t RIGHT_UP   = '{1'b0, 1'b0, 1'b1, 1'b0};
    localparam buttons_t RIGHT_DOWN = '{1'b0, 1'b0, 1'b0, 1'b1};

    logic     clk;
    logic     rst;
    buttons_t buttons;
    paddles_t paddles;
    ball_t    ball;
    logic     serving;
    int       errors = 0;
    int       checks = 0;
    int       tests  = 0;
    int       cycles = 0;

    tb_clock i_clock (
        .clk (clk),
        .rst (rst)
    );

    pong_game i_dut (
        .clk     (clk),
        .rst     (rst),
        .buttons (buttons),
        .paddles (paddles),
        .ball    (ball),
        .serving (serving)
    );

    function automatic ball_t make_ball(input int x, input int y, input xdir_e xdir,
                                        input ydir_e ydir, input int xvel, input int yvel);
        ball_t b;
        b.x    = x_t'(x);
        b.y    = y_t'(y);
        b.xdir = xdir;
        b.ydir = ydir;
        b.xvel = vel_t'(xvel);
        b.yvel = vel_t'(yvel);
        return b;
    endfunction

    function automatic paddles_t make_paddles(input int left_y, input int right_y);
        paddles_t p;
        p.left_y  = y_t'(left_y);
        p.right_y = y_t'(right_y);
        return p;
    endfunction

    // x advances by xvel toward xdir and nothing else changes
    function automatic ball_t step_flat(input ball_t prev);
        ball_t nxt;
        nxt = prev;
        if (prev.xdir == XDIR_LEFT) begin
            nxt.x = x_t'(int'(prev.x) - int'(prev.xvel));
        end else begin
            nxt.x = x_t'(int'(prev.x) + int'(prev.xvel));
        end
        return nxt;
    endfunction

    function automatic string fmt_ball(input ball_t b);
        return $sformatf("x=%0d y=%0d xdir=%0d ydir=%0d xvel=%0d yvel=%0d",
                         b.x, b.y, b.xdir, b.ydir, b.xvel, b.yvel);
    endfunction

    task automatic check_ball(input string name, input ball_t got, input ball_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s = {%s}, expected {%s}", $time, name,
                     fmt_ball(got), fmt_ball(exp));
        end
    endtask

    task automatic check_paddles(input string name, input paddles_t got, input paddles_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s = %0d/%0d, expected %0d/%0d", $time, name,
                     got.left_y, got.right_y, exp.left_y, exp.right_y);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests++;
        $display("test %-14s done, %0d errors", name, errors - errs_before);
    endtask

    // n separate presses of one cycle high and one low
    task automatic press_buttons(input buttons_t b, input int n);
        repeat (n) begin
            @(posedge clk);
            buttons <= b;
            @(posedge clk);
            buttons <= '0;
        end
        repeat (4) @(posedge clk);  // sync stages plus the paddle update
        @(negedge clk);
    endtask

    task automatic wait_ball_change(input ball_t prev, output ball_t now);
        @(negedge clk);
        while (ball == prev) begin
            @(negedge clk);
        end
        now = ball;
    endtask

    task automatic test_reset_state();
        int start;
        start = errors;
        @(negedge clk);
        while (rst) begin
            @(negedge clk);
        end
        check_bit("serving", serving, 1'b1);
        check_paddles("paddles", paddles, make_paddles(225, 225));
        check_ball("ball", ball, make_ball(197, 295, XDIR_LEFT, YDIR_PARALLEL, 0, 0));
        finish_test("reset", start);
    endtask

    task automatic test_first_serve();
        ball_t prev;
        ball_t now;
        int    start;
        start = errors;
        while (serving) begin
            @(negedge clk);
        end
        check_ball("ball", ball, make_ball(197, 295, XDIR_LEFT, YDIR_PARALLEL, 3, 0));
        prev = ball;
        repeat (4) begin
            wait_ball_change(prev, now);
            check_ball("ball", now, step_flat(prev));  // x drops by 3 while y stays 295
            prev = now;
        end
        finish_test("first serve", start);
    endtask

    task automatic test_paddle_moves();
        int start;
        start = errors;
        @(posedge clk);
        buttons <= LEFT_UP;  // drive edge N
        @(negedge clk);
        repeat (2) begin
            @(negedge clk);
            check_paddles("paddles", paddles, make_paddles(225, 225));
        end
        @(negedge clk);      // after edge N+3
        check_paddles("paddles", paddles, make_paddles(217, 225));
        repeat (8) @(negedge clk);
        check_paddles("paddles", paddles, make_paddles(217, 225));  // held button gives no repeat
        @(posedge clk);
        buttons <= '0;
        press_buttons(RIGHT_DOWN, 30);
        check_paddles("paddles", paddles, make_paddles(217, 450));  // clamped at the bottom
        press_buttons(RIGHT_UP, 28);  // 226 puts y=295 in the centre band
        press_buttons(LEFT_DOWN, 1);
        check_paddles("paddles", paddles, make_paddles(225, 226));
        finish_test("paddle moves", start);
    endtask

    task automatic test_paddles_cancel();
        int start;
        start = errors;
        press_buttons(LEFT_BOTH, 1);
        check_paddles("paddles", paddles, make_paddles(225, 226));
        finish_test("paddle cancel", start);
    endtask

    task automatic test_paddle_bounce();
        ball_t prev;
        ball_t now;
        ball_t exp;
        bit    done;
        int    start;
        start = errors;
        done  = 1'b0;
        prev  = ball;
        while (!done) begin
            wait_ball_change(prev, now);
            if (prev.xdir == XDIR_LEFT && int'(prev.x) == 20) begin
                exp = make_ball(23, 295, XDIR_RIGHT, YDIR_PARALLEL, 3, 0);  // left centre hit
            end else if (prev.xdir == XDIR_RIGHT && int'(prev.x) == 377) begin
                exp  = make_ball(374, 295, XDIR_LEFT, YDIR_PARALLEL, 3, 0);
                done = 1'b1;
            end else begin
                exp = step_flat(prev);
            end
            check_ball("ball", now, exp);
            check_bit("serving", serving, 1'b0);
            prev = now;
        end
        finish_test("paddle bounce", start);
    endtask

    task automatic test_score_and_serve();
        ball_t prev;
        ball_t now;
        int    start;
        int    delay;
        start = errors;
        press_buttons(LEFT_UP, 29);  // left paddle out of the way
        check_paddles("paddles", paddles, make_paddles(0, 226));
        prev = ball;
        while (!serving) begin
            wait_ball_change(prev, now);
            check_ball("ball", now, step_flat(prev));
            // the ball heads left so only the left face can be passed
            check_bit("serving", serving, int'(prev.x) < 17);
            prev = now;
        end
        @(negedge clk);
        check_ball("ball", ball, make_ball(197, 295, XDIR_LEFT, YDIR_PARALLEL, 0, 0));
        delay = 1;
        while (serving) begin
            @(negedge clk);
            delay++;
        end
        checks++;
        if (delay != SERVE_DELAY_CYCLES) begin
            errors++;
            $display("serve lasted %0d cycles instead of %0d", delay, SERVE_DELAY_CYCLES);
        end
        check_ball("ball", ball, make_ball(197, 295, XDIR_LEFT, YDIR_PARALLEL, 3, 0));
        finish_test("score and serve", start);
    endtask

    task automatic test_edge_and_wall();
        ball_t prev;
        ball_t now;
        ball_t exp;
        bit    done;
        int    start;
        start = errors;
        done  = 1'b0;
        press_buttons(LEFT_DOWN, 19);  // y=295 falls in the lower edge strip of 152..302
        check_paddles("paddles", paddles, make_paddles(152, 226));
        prev = ball;
        while (!done) begin
            wait_ball_change(prev, now);
            exp = step_flat(prev);
            if (prev.xdir == XDIR_LEFT && int'(prev.x) == 20) begin
                exp = make_ball(21, 295, XDIR_RIGHT, YDIR_DOWN, 1, 3);  // lower edge hit
            end else if (prev.xdir == XDIR_RIGHT) begin
                if (int'(prev.y) == 589) begin
                    exp.y    = y_t'(586);        // bottom of the ball would reach 600
                    exp.ydir = YDIR_UP;
                end else if (prev.ydir == YDIR_DOWN) begin
                    exp.y = y_t'(int'(prev.y) + 3);
                end else begin
                    exp.y = y_t'(int'(prev.y) - 3);
                    done  = 1'b1;
                end
            end
            check_ball("ball", now, exp);
            check_bit("serving", serving, 1'b0);
            prev = now;
        end
        finish_test("edge and wall", start);
    endtask

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the game stopped making progress", cycles);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        buttons = '0;
        test_reset_state();
        test_first_serve();
        test_paddle_moves();
        test_paddles_cancel();
        test_paddle_bounce();
        test_score_and_serve();
        test_edge_and_wall();
        if (i_dut.i_ball_ctrl.i_pong_props.violations != 0) begin
            errors++;
            $display("assertions in ball_ctrl failed %0d times",
                     i_dut.i_ball_ctrl.i_pong_props.violations);
        end
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
